// File: demux_params.svh
/*
 * Shared constants of the APB address demultiplexer
 *   Bus widths for address and data
 *   Rule count, master port count and port index width
 *   Register offsets of the configuration port
 */
`ifndef DEMUX_PARAMS_SVH
`define DEMUX_PARAMS_SVH

// Width of every APB address, on the upstream, downstream and configuration ports
`define ADDR_W 32
// Width of read and write data
`define DATA_W 32

// Number of rules in the programmable address map
`define NUM_RULES 4
// Number of downstream APB master ports
`define NUM_PORTS 4
// Bits needed to name one master port
`define IDX_W 2

// Offset of the control register on the configuration port
`define CFG_CTRL_OFFS 32'h100
// Byte distance between the register groups of two neighbouring rules
`define CFG_RULE_STRIDE 16

`endif

// File: apb_demux_pkg.sv
/*
 * Types of the APB address demultiplexer
 *   APB request and response structs
 *   Rule, address map and control register types
 *   Decode result and the item handed between the pipeline stages
 *   State and register-field enums
 */
`include "demux_params.svh"

package apb_demux_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`IDX_W-1:0]  idx_t;

  // One APB request as seen by a slave
  typedef struct packed {
    logic  sel;
    logic  enable;
    addr_t addr;
    logic  write;
    data_t wdata;
  } apb_req_t;

  // One APB response as driven by a slave
  typedef struct packed {
    logic  ready;
    data_t rdata;
    logic  slverr;
  } apb_rsp_t;

  // Start is inside the range, end is outside, an end of zero runs to the top
  typedef struct packed {
    idx_t  idx;
    addr_t start_addr;
    addr_t end_addr;
  } rule_t;

  // Rule with the highest position wins when ranges overlap
  typedef rule_t [`NUM_RULES-1:0] addr_map_t;

  // Control register, read and written in its low bits in this field order
  typedef struct packed {
    logic config_ongoing;
    logic en_default;
    idx_t default_idx;
  } cfg_ctrl_t;

  typedef struct packed {
    idx_t idx;
    logic valid;
    logic error;
  } dec_result_t;

  // Captured upstream request together with its routing decision
  typedef struct packed {
    logic        valid;
    apb_req_t    req;
    dec_result_t dec;
  } stage_req_t;

  typedef enum logic [1:0] {ST_IDLE, ST_DECODE, ST_HOLD} decode_state_e;

  typedef enum logic [1:0] {MX_IDLE, MX_SETUP, MX_ACCESS, MX_RESPOND} mux_state_e;

  typedef enum logic [2:0] {CF_START, CF_END, CF_IDX, CF_CTRL, CF_NONE} cfg_field_e;

endpackage

// File: addr_map_regs.sv
/*
 * APB configuration slave of the demultiplexer
 *   Holds the rule table and the control register
 *   Answers in the access cycle with zero wait states
 *   Unmapped offsets complete with a slave error
 */
`include "demux_params.svh"
`timescale 1ns/100ps

module addr_map_regs import apb_demux_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  apb_req_t  cfg_req_i,
  output apb_rsp_t  cfg_rsp_o,
  output addr_map_t addr_map_o,
  output cfg_ctrl_t cfg_ctrl_o
);

  // Bits to select one rule, and the offset range taken by all rule groups
  localparam int unsigned RuleW    = (`NUM_RULES > 1) ? $clog2(`NUM_RULES) : 1;
  localparam int unsigned RuleSpan = `NUM_RULES * `CFG_RULE_STRIDE;

  addr_map_t          map_q;
  cfg_ctrl_t          ctrl_q;
  cfg_field_e         field;
  logic [RuleW-1:0]   rule_sel;
  logic [`ADDR_W-1:0] offs_in_rule;
  logic               access;
  data_t              rdata;

  // Transfers act only in the access phase
  assign access = cfg_req_i.sel & cfg_req_i.enable;

  // Position of the address inside one rule group
  assign offs_in_rule = cfg_req_i.addr % `CFG_RULE_STRIDE;

  // Classify the offset into a register field and a rule number
  always_comb begin
    field    = CF_NONE;
    rule_sel = '0;
    if (cfg_req_i.addr == `CFG_CTRL_OFFS) begin
      field = CF_CTRL;
    end else if (cfg_req_i.addr < RuleSpan) begin
      rule_sel = RuleW'(cfg_req_i.addr / `CFG_RULE_STRIDE);
      case (offs_in_rule)
        'd0:     field = CF_START;
        'd4:     field = CF_END;
        'd8:     field = CF_IDX;
        // The gap at offset 12 of each group is not a register
        default: field = CF_NONE;
      endcase
    end
  end

  // Register writes land at the end of the access cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      map_q  <= '0;
      ctrl_q <= '0;
    end else if (access && cfg_req_i.write) begin
      case (field)
        CF_START: map_q[rule_sel].start_addr <= `ADDR_W'(cfg_req_i.wdata);
        CF_END:   map_q[rule_sel].end_addr   <= `ADDR_W'(cfg_req_i.wdata);
        // Only the low index bits are kept so every stored index names a port
        CF_IDX:   map_q[rule_sel].idx        <= cfg_req_i.wdata[`IDX_W-1:0];
        CF_CTRL:  ctrl_q <= cfg_ctrl_t'(cfg_req_i.wdata[$bits(cfg_ctrl_t)-1:0]);
        default:  ;
      endcase
    end
  end

  // Read mux, narrow fields come back zero extended
  always_comb begin
    rdata = '0;
    case (field)
      CF_START: rdata = `DATA_W'(map_q[rule_sel].start_addr);
      CF_END:   rdata = `DATA_W'(map_q[rule_sel].end_addr);
      CF_IDX:   rdata = `DATA_W'(map_q[rule_sel].idx);
      CF_CTRL:  rdata = `DATA_W'(ctrl_q);
      default:  rdata = '0;
    endcase
  end

  // Zero wait states, so ready follows the access phase directly
  assign cfg_rsp_o.ready  = access;
  assign cfg_rsp_o.rdata  = (access && !cfg_req_i.write) ? rdata : '0;
  assign cfg_rsp_o.slverr = access && (field == CF_NONE);

  assign addr_map_o = map_q;
  assign cfg_ctrl_o = ctrl_q;

endmodule

// File: addr_decode_dync.sv
/*
 * Combinational address decoder with a run-time address map
 *   Range rules only, start included and end excluded
 *   Higher-numbered rules win on overlap
 *   Optional default port when no rule matches
 */
`include "demux_params.svh"
`timescale 1ns/100ps

module addr_decode_dync import apb_demux_pkg::*; (
  input  addr_t       addr_i,
  input  addr_map_t   addr_map_i,
  input  logic        en_default_idx_i,
  input  idx_t        default_idx_i,
  input  logic        config_ongoing_i,
  output dec_result_t result_o
);

  always_comb begin
    // Without a match the default port is taken if enabled, else it is an error
    result_o.valid = en_default_idx_i;
    result_o.error = ~en_default_idx_i;
    result_o.idx   = en_default_idx_i ? default_idx_i : '0;

    // Later rules overwrite earlier ones, so the highest matching rule wins
    for (int unsigned i = 0; i < `NUM_RULES; i++) begin
      if ((addr_i >= addr_map_i[i].start_addr) &&
          ((addr_i < addr_map_i[i].end_addr) || (addr_map_i[i].end_addr == '0))) begin
        // A match during reconfiguration is held back, neither valid nor error
        result_o.valid = ~config_ongoing_i;
        result_o.error = 1'b0;
        result_o.idx   = config_ongoing_i ? default_idx_i : addr_map_i[i].idx;
      end
    end
  end

  // Note that a rule with start and end both zero covers the whole space,
  // which is what every rule looks like straight after reset

endmodule

// File: apb_decode_stage.sv
/*
 * First pipeline stage of the demultiplexer
 *   Captures an upstream request on its setup cycle
 *   Waits for a definite decode result
 *   Holds the request and its decision until the port mux is done
 */
`include "demux_params.svh"
`timescale 1ns/100ps

module apb_decode_stage import apb_demux_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  apb_req_t    slv_req_i,
  output addr_t       dec_addr_o,
  input  dec_result_t dec_i,
  output stage_req_t  item_o,
  input  logic        done_i
);

  decode_state_e state_q;
  decode_state_e state_d;
  apb_req_t      req_q;
  dec_result_t   dec_q;
  logic          setup;
  logic          decided;

  // Setup phase of a new upstream transfer
  assign setup = slv_req_i.sel & ~slv_req_i.enable;

  // The decoder gave either a port or an error
  assign decided = dec_i.valid | dec_i.error;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (setup) begin
          state_d = ST_DECODE;
        end
      end
      ST_DECODE: begin
        // Stays here while reconfiguration holds back a matched rule
        if (decided) begin
          state_d = ST_HOLD;
        end
      end
      ST_HOLD: begin
        if (done_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and decision are payload, loaded only on the matching transitions
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_IDLE) && setup) begin
      req_q <= slv_req_i;
    end
    if ((state_q == ST_DECODE) && decided) begin
      dec_q <= dec_i;
    end
  end

  // The decoder always looks at the captured address
  assign dec_addr_o = req_q.addr;

  // The item is offered from the cycle after the decision until done
  assign item_o.valid = (state_q == ST_HOLD);
  assign item_o.req   = req_q;
  assign item_o.dec   = dec_q;

endmodule

// File: apb_port_mux.sv
/*
 * Second pipeline stage of the demultiplexer
 *   Runs setup and access on the selected master port
 *   Latches read data and slave error from that port
 *   Returns one upstream response cycle, or a slave error for unmapped items
 */
`include "demux_params.svh"
`timescale 1ns/100ps

module apb_port_mux import apb_demux_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  stage_req_t                item_i,
  output logic                      done_o,
  output apb_req_t [`NUM_PORTS-1:0] mst_req_o,
  input  apb_rsp_t [`NUM_PORTS-1:0] mst_rsp_i,
  output apb_rsp_t                  slv_rsp_o
);

  mux_state_e state_q;
  mux_state_e state_d;
  data_t      rdata_q;
  logic       slverr_q;
  idx_t       port;

  // The decode stage holds the item until done, so the index stays stable
  assign port = item_i.dec.idx;

  always_comb begin
    state_d = state_q;
    case (state_q)
      MX_IDLE: begin
        // Errors skip the master ports and answer straight away
        if (item_i.valid && item_i.dec.error) begin
          state_d = MX_RESPOND;
        end else if (item_i.valid && item_i.dec.valid) begin
          state_d = MX_SETUP;
        end
      end
      MX_SETUP:  state_d = MX_ACCESS;
      MX_ACCESS: begin
        // A slow slave keeps us here as long as it likes
        if (mst_rsp_i[port].ready) begin
          state_d = MX_RESPOND;
        end
      end
      MX_RESPOND: state_d = MX_IDLE;
      default:    state_d = MX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= MX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Response payload, either from the slave or the fixed error answer
  always_ff @(posedge clk_i) begin
    if ((state_q == MX_IDLE) && item_i.valid && item_i.dec.error) begin
      rdata_q  <= '0;
      slverr_q <= 1'b1;
    end else if ((state_q == MX_ACCESS) && mst_rsp_i[port].ready) begin
      rdata_q  <= mst_rsp_i[port].rdata;
      slverr_q <= mst_rsp_i[port].slverr;
    end
  end

  // Only the selected port sees select, all others stay quiet
  always_comb begin
    for (int p = 0; p < `NUM_PORTS; p++) begin
      mst_req_o[p] = '0;
      if ((idx_t'(p) == port) &&
          ((state_q == MX_SETUP) || (state_q == MX_ACCESS))) begin
        mst_req_o[p].sel    = 1'b1;
        mst_req_o[p].enable = (state_q == MX_ACCESS);
        mst_req_o[p].addr   = item_i.req.addr;
        mst_req_o[p].write  = item_i.req.write;
        mst_req_o[p].wdata  = item_i.req.wdata;
      end
    end
  end

  // Upstream ready lasts exactly the one respond cycle
  assign slv_rsp_o.ready  = (state_q == MX_RESPOND);
  assign slv_rsp_o.rdata  = (state_q == MX_RESPOND) ? rdata_q : '0;
  assign slv_rsp_o.slverr = (state_q == MX_RESPOND) && slverr_q;

  // Completion tells the decode stage to release its item
  assign done_o = (state_q == MX_RESPOND);

endmodule

// File: apb_demux_top.sv
/*
 * Top level of the APB address demultiplexer
 *   Configuration slave with the rule table
 *   Address decoder, decode stage and port mux
 */
`include "demux_params.svh"
`timescale 1ns/100ps

module apb_demux_top import apb_demux_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  apb_req_t                  slv_req_i,
  output apb_rsp_t                  slv_rsp_o,
  input  apb_req_t                  cfg_req_i,
  output apb_rsp_t                  cfg_rsp_o,
  output apb_req_t [`NUM_PORTS-1:0] mst_req_o,
  input  apb_rsp_t [`NUM_PORTS-1:0] mst_rsp_i
);

  addr_map_t   addr_map;
  cfg_ctrl_t   cfg_ctrl;
  addr_t       dec_addr;
  dec_result_t dec_result;
  stage_req_t  item;
  logic        item_done;

  // Software-visible rule table and control register
  addr_map_regs u_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cfg_req_i  (cfg_req_i),
    .cfg_rsp_o  (cfg_rsp_o),
    .addr_map_o (addr_map),
    .cfg_ctrl_o (cfg_ctrl)
  );

  addr_decode_dync u_decode (
    .addr_i           (dec_addr),
    .addr_map_i       (addr_map),
    .en_default_idx_i (cfg_ctrl.en_default),
    .default_idx_i    (cfg_ctrl.default_idx),
    .config_ongoing_i (cfg_ctrl.config_ongoing),
    .result_o         (dec_result)
  );

  // Capture and decide
  apb_decode_stage u_stage (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .slv_req_i  (slv_req_i),
    .dec_addr_o (dec_addr),
    .dec_i      (dec_result),
    .item_o     (item),
    .done_i     (item_done)
  );

  // Forward and respond
  apb_port_mux u_mux (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .item_i    (item),
    .done_o    (item_done),
    .mst_req_o (mst_req_o),
    .mst_rsp_i (mst_rsp_i),
    .slv_rsp_o (slv_rsp_o)
  );

endmodule

// File: tb_apb_demux.sv
/*
 * Directed testbench of the APB address demultiplexer
 *   Four APB slave models with memories, random wait states and transfer counts
 *   Bus tasks for the configuration port and the upstream port
 *   Compare tasks for responses, rules, control and transfer counts
 *   Tests for readback, routing, priority, default port and reconfiguration
 */
`include "demux_params.svh"
`timescale 1ns/100ps

module tb_apb_demux import apb_demux_pkg::*; ();

  localparam int NumTests = 5;

  logic                      clk;
  logic                      reset;
  apb_req_t                  slv_req;
  apb_rsp_t                  slv_rsp;
  apb_req_t                  cfg_req;
  apb_rsp_t                  cfg_rsp;
  apb_req_t [`NUM_PORTS-1:0] mst_req;
  apb_rsp_t [`NUM_PORTS-1:0] mst_rsp;

  // Slave model state with one entry per master port
  data_t mem [`NUM_PORTS][16];
  int    wait_left [`NUM_PORTS];
  int    xfer_cnt [`NUM_PORTS];
  int    base_cnt [`NUM_PORTS];
  int    seed;

  apb_demux_top u_dut (
    .clk_i     (clk),
    .reset_i   (reset),
    .slv_req_i (slv_req),
    .slv_rsp_o (slv_rsp),
    .cfg_req_i (cfg_req),
    .cfg_rsp_o (cfg_rsp),
    .mst_req_o (mst_req),
    .mst_rsp_i (mst_rsp)
  );

  always #10 clk = ~clk;

  // Slave models look at the settled master requests just after each edge
  always @(posedge clk) begin
    logic [3:0] word;
    #2;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      mst_rsp[p] = '0;
      word = mst_req[p].addr[5:2];
      if (mst_req[p].sel && !mst_req[p].enable) begin
        // A fresh wait-state count for every transfer
        wait_left[p] = $unsigned($random(seed)) % 4;
      end else if (mst_req[p].sel && mst_req[p].enable) begin
        if (wait_left[p] > 0) begin
          wait_left[p]--;
        end else begin
          mst_rsp[p].ready = 1'b1;
          if (mst_req[p].write) begin
            mem[p][word] = mst_req[p].wdata;
          end else begin
            mst_rsp[p].rdata = mem[p][word];
          end
          xfer_cnt[p]++;
        end
      end
    end
  end

  task automatic stop_with_error(string line);
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped after the first failure");
  endtask

  function automatic apb_rsp_t make_rsp(logic slverr, data_t rdata);
    apb_rsp_t rsp;
    rsp.ready  = 1'b1;
    rsp.rdata  = rdata;
    rsp.slverr = slverr;
    return rsp;
  endfunction

  // Offset of one register inside the group of rule r
  function automatic addr_t rule_reg(int r, int field_offs);
    return addr_t'(r * `CFG_RULE_STRIDE + field_offs);
  endfunction

  task automatic check_rsp(apb_rsp_t got, apb_rsp_t exp, string what);
    if (got !== exp) begin
      stop_with_error($sformatf(
        "ERROR at %0t ns: %s gave ready %0b rdata %h slverr %0b, expected %0b %h %0b",
        $time, what, got.ready, got.rdata, got.slverr, exp.ready, exp.rdata, exp.slverr));
    end
  endtask

  task automatic check_rule(rule_t got, rule_t exp, int r);
    if (got !== exp) begin
      stop_with_error($sformatf(
        "ERROR at %0t ns: rule %0d read %h..%h idx %0d, expected %h..%h idx %0d",
        $time, r, got.start_addr, got.end_addr, got.idx,
        exp.start_addr, exp.end_addr, exp.idx));
    end
  endtask

  task automatic check_ctrl(cfg_ctrl_t got, cfg_ctrl_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("ERROR at %0t ns: control read %b, expected %b",
                                $time, got, exp));
    end
  endtask

  task automatic check_count(int port, int got, int exp);
    if (got != exp) begin
      stop_with_error($sformatf("ERROR at %0t ns: port %0d saw %0d transfers, expected %0d",
                                $time, port, got, exp));
    end
  endtask

  task automatic snap_counts();
    base_cnt = xfer_cnt;
  endtask

  // Only the target port may have gained transfers since the last snapshot
  task automatic check_counts(int target, int added);
    for (int p = 0; p < `NUM_PORTS; p++) begin
      check_count(p, xfer_cnt[p], base_cnt[p] + ((p == target) ? added : 0));
    end
  endtask

  // The configuration port has zero wait states so ready shows in the access cycle
  task automatic cfg_access(addr_t addr, logic write, data_t wdata, output apb_rsp_t rsp);
    @(posedge clk);
    #2;
    cfg_req = '{sel: 1'b1, enable: 1'b0, addr: addr, write: write, wdata: wdata};
    @(posedge clk);
    #2;
    cfg_req.enable = 1'b1;
    @(negedge clk);
    rsp = cfg_rsp;
    @(posedge clk);
    #2;
    cfg_req = '0;
  endtask

  task automatic cfg_write(addr_t addr, data_t wdata);
    apb_rsp_t rsp;
    cfg_access(addr, 1'b1, wdata, rsp);
    check_rsp(rsp, make_rsp(1'b0, '0), "config write");
  endtask

  task automatic cfg_read(addr_t addr, output apb_rsp_t rsp);
    cfg_access(addr, 1'b0, '0, rsp);
  endtask

  // The raw response of the index read is handed back for a full-word check
  task automatic read_rule(int r, output rule_t rule, output apb_rsp_t idx_rsp);
    apb_rsp_t rsp;
    cfg_read(rule_reg(r, 0), rsp);
    rule.start_addr = rsp.rdata;
    cfg_read(rule_reg(r, 4), rsp);
    rule.end_addr = rsp.rdata;
    cfg_read(rule_reg(r, 8), idx_rsp);
    rule.idx = idx_t'(idx_rsp.rdata);
  endtask

  // Drives the upstream setup and access phases and leaves the wait for ready to apb_finish
  task automatic apb_start(addr_t addr, logic write, data_t wdata);
    @(posedge clk);
    #2;
    slv_req = '{sel: 1'b1, enable: 1'b0, addr: addr, write: write, wdata: wdata};
    @(posedge clk);
    #2;
    slv_req.enable = 1'b1;
  endtask

  task automatic apb_finish(output apb_rsp_t rsp);
    @(negedge clk);
    while (!slv_rsp.ready) begin
      @(negedge clk);
    end
    rsp = slv_rsp;
    @(posedge clk);
    #2;
    slv_req = '0;
  endtask

  task automatic apb_write(addr_t addr, data_t wdata, output apb_rsp_t rsp);
    apb_start(addr, 1'b1, wdata);
    apb_finish(rsp);
  endtask

  task automatic apb_read(addr_t addr, output apb_rsp_t rsp);
    apb_start(addr, 1'b0, '0);
    apb_finish(rsp);
  endtask

  // Write then read back one address that must land on the given port
  task automatic route_check(addr_t addr, int port, data_t data);
    apb_rsp_t rsp;
    snap_counts();
    apb_write(addr, data, rsp);
    check_rsp(rsp, make_rsp(1'b0, '0), "routed write");
    check_counts(port, 1);
    snap_counts();
    apb_read(addr, rsp);
    check_rsp(rsp, make_rsp(1'b0, data), "routed read");
    check_counts(port, 1);
  endtask

  // Rule r covers 0x1000*(r+1) up to the next 4 KiB and goes to port 3-r
  task automatic test_cfg_readback();
    rule_t     exp_rule;
    rule_t     got_rule;
    cfg_ctrl_t exp_ctrl;
    apb_rsp_t  rsp;
    for (int r = 0; r < `NUM_RULES; r++) begin
      exp_rule.start_addr = addr_t'(32'h1000 * (r + 1));
      exp_rule.end_addr   = addr_t'(32'h1000 * (r + 2));
      exp_rule.idx        = idx_t'(3 - r);
      cfg_write(rule_reg(r, 0), exp_rule.start_addr);
      cfg_write(rule_reg(r, 4), exp_rule.end_addr);
      // Bit 2 is set so that the cut to the low index bits shows
      cfg_write(rule_reg(r, 8), data_t'(4 + 3 - r));
      read_rule(r, got_rule, rsp);
      check_rule(got_rule, exp_rule, r);
      // The whole index word comes back with its upper bits cleared
      check_rsp(rsp, make_rsp(1'b0, data_t'(exp_rule.idx)), "index readback");
    end
    exp_ctrl.config_ongoing = 1'b0;
    exp_ctrl.en_default     = 1'b1;
    exp_ctrl.default_idx    = idx_t'(1);
    cfg_write(`CFG_CTRL_OFFS, 32'hFFFF_FFF5);
    cfg_read(`CFG_CTRL_OFFS, rsp);
    check_ctrl(cfg_ctrl_t'(rsp.rdata[$bits(cfg_ctrl_t)-1:0]), exp_ctrl);
    check_rsp(rsp, make_rsp(1'b0, data_t'(exp_ctrl)), "control readback");
    cfg_write(`CFG_CTRL_OFFS, '0);
    cfg_read(32'h0000_000C, rsp);
    check_rsp(rsp, make_rsp(1'b1, '0), "config read of gap offset");
    cfg_read(32'h0000_0200, rsp);
    check_rsp(rsp, make_rsp(1'b1, '0), "config read of unmapped offset");
  endtask

  task automatic test_routing();
    addr_t addr;
    for (int k = 0; k < 2; k++) begin
      for (int r = 0; r < `NUM_RULES; r++) begin
        addr = addr_t'(32'h1000 * (r + 1) + 32'h24 * (k + 1));
        route_check(addr, 3 - r, 32'h5A00_0000 ^ addr);
      end
    end
  endtask

  task automatic test_priority();
    // Rule 3 overlaps the top of rule 0 and wins there
    cfg_write(rule_reg(3, 0), 32'h0000_1800);
    cfg_write(rule_reg(3, 4), 32'h0000_2800);
    route_check(32'h0000_1900, 0, 32'h1111_0001);
    route_check(32'h0000_1000, 3, 32'h1111_0002);
    // The end address of rule 3 lies outside rule 3 and falls to rule 1
    route_check(32'h0000_2800, 2, 32'h1111_0006);
    // End of zero opens rule 3 up to the top of the address space
    cfg_write(rule_reg(3, 0), 32'hF000_0000);
    cfg_write(rule_reg(3, 4), 32'h0000_0000);
    route_check(32'hFFFF_FFFC, 0, 32'h1111_0003);
    route_check(32'hF000_0000, 0, 32'h1111_0004);
    route_check(32'h0000_1900, 3, 32'h1111_0005);
  endtask

  task automatic test_default();
    apb_rsp_t rsp;
    snap_counts();
    apb_read(32'h0000_8000, rsp);
    check_rsp(rsp, make_rsp(1'b1, '0), "unmatched read");
    apb_write(32'h0000_8000, 32'hDEAD_BEEF, rsp);
    check_rsp(rsp, make_rsp(1'b1, '0), "unmatched write");
    check_counts(-1, 0);
    // Default enabled towards port 2
    cfg_write(`CFG_CTRL_OFFS, 32'h0000_0006);
    route_check(32'h0000_8000, 2, 32'h2222_0001);
    cfg_write(`CFG_CTRL_OFFS, '0);
  endtask

  task automatic test_config_ongoing();
    apb_rsp_t rsp;
    cfg_write(`CFG_CTRL_OFFS, 32'h0000_0008);
    // Rule 1 moves from port 2 to port 1 while the flag is up
    cfg_write(rule_reg(1, 8), 32'h0000_0001);
    snap_counts();
    apb_start(32'h0000_2040, 1'b1, 32'h3333_0001);
    repeat (50) begin
      @(negedge clk);
      if (slv_rsp.ready) begin
        stop_with_error("Upstream ready came while the configuration flag was set");
      end
    end
    cfg_write(`CFG_CTRL_OFFS, '0);
    apb_finish(rsp);
    check_rsp(rsp, make_rsp(1'b0, '0), "write held by reconfiguration");
    check_counts(1, 1);
    route_check(32'h0000_2040, 1, 32'h3333_0002);
  endtask

  // Watchdog sized from the number of tests
  initial begin
    repeat (NumTests * 2000) @(posedge clk);
    stop_with_error("Timeout: the tests did not finish within the cycle budget");
  end

  initial begin
    clk     = 1'b0;
    reset   = 1'b1;
    slv_req = '0;
    cfg_req = '0;
    mst_rsp = '0;
    seed    = 32'hd0c1996b;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      wait_left[p] = 0;
      xfer_cnt[p]  = 0;
      for (int w = 0; w < 16; w++) begin
        mem[p][w] = 32'hA500_0000 | data_t'(p * 256 + w);
      end
    end
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    test_cfg_readback();
    test_routing();
    test_priority();
    test_default();
    test_config_ongoing();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
apb_demux_pkg.sv
addr_map_regs.sv
addr_decode_dync.sv
apb_decode_stage.sv
apb_port_mux.sv
apb_demux_top.sv
tb_apb_demux.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the APB demultiplexer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_apb_demux

verilator --binary --timing --top-module "$TOP" -f verilog.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
  echo "Simulation result: pass"
  exit 0
else
  echo "Simulation result: fail"
  exit 1
fi
